//--- ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Data and address width
`define OOO_XLEN 32

// Architectural registers
`define OOO_NREGS 32

// Completion buffer entries, power of two
`define OOO_CB_DEPTH 8

// Counters in the branch history table, power of two
`define OOO_BHT_ENTRIES 16

`endif

//--- ooo_types_pkg.sv
`include "ooo_cfg.svh"

package ooo_types_pkg;

  typedef logic [`OOO_XLEN-1:0]              word_t;     // Data or address
  typedef logic [$clog2(`OOO_NREGS)-1:0]     reg_idx_t;  // Architectural register
  typedef logic [$clog2(`OOO_CB_DEPTH)-1:0]  cb_idx_t;   // Completion buffer slot
  typedef logic [1:0]                        bht_ctr_t;  // Saturating counter

  // Kind of result coming back on the writeback lane
  typedef enum logic [2:0] {
    RK_ALU,
    RK_LOAD,
    RK_STORE,
    RK_JUMP,
    RK_BRANCH
  } result_kind_t;

  // Encodings match mcause, EXC_NONE sits outside that range
  typedef enum logic [3:0] {
    EXC_NONE      = 4'd15,
    EXC_MAL_INSN  = 4'd0,
    EXC_MAL_LOAD  = 4'd4,
    EXC_MAL_STORE = 4'd6
  } exc_cause_t;

  typedef enum logic {
    CB_RUN,
    CB_FLUSH
  } cb_state_t;

endpackage

//--- commit_wb_if.sv
`timescale 1ns/1ns

interface commit_wb_if import ooo_types_pkg::*; ();

  logic       wen;         // Write one buffer entry
  cb_idx_t    index;
  word_t      wdata;
  reg_idx_t   rd;
  exc_cause_t exc_cause;   // EXC_NONE when clean
  word_t      badaddr;
  logic       mispredict;
  word_t      redirect;    // Correct next PC of a branch
  logic       flush;       // Buffer is discarding, drop results

  modport stage (
    output wen, index, wdata, rd, exc_cause, badaddr, mispredict, redirect,
    input  flush
  );

  modport buffer (
    input  wen, index, wdata, rd, exc_cause, badaddr, mispredict, redirect,
    output flush
  );

endinterface

//--- ooo_commit_stage.sv
`timescale 1ns/1ns

module ooo_commit_stage import ooo_types_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         res_valid,
  input  cb_idx_t      res_index,
  input  result_kind_t res_kind,
  input  word_t        res_pc,
  input  word_t        res_wdata,
  input  word_t        res_addr,
  input  reg_idx_t     res_rd,
  input  logic         res_taken,
  input  logic         res_pred,
  commit_wb_if.stage   wb,
  output logic         upd_valid,
  output word_t        upd_pc,
  output logic         upd_taken
);

  logic       accept;
  logic       addr_mis;
  logic       is_branch;
  logic       mispredict;
  exc_cause_t cause;
  word_t      redirect;

  assign accept    = res_valid && !wb.flush;      // Results during a flush are lost
  assign addr_mis  = (res_addr[1:0] != 2'b00);
  assign is_branch = (res_kind == RK_BRANCH);

  // Memory address for load/store, target for jump/branch
  always_comb begin
    cause = EXC_NONE;
    if (addr_mis) begin
      case (res_kind)
        RK_LOAD:   cause = EXC_MAL_LOAD;
        RK_STORE:  cause = EXC_MAL_STORE;
        RK_JUMP:   cause = EXC_MAL_INSN;
        RK_BRANCH: begin
          if (res_taken) begin
            cause = EXC_MAL_INSN;       // Not-taken target is never fetched
          end
        end
        default:   cause = EXC_NONE;
      endcase
    end
  end

  assign mispredict = is_branch && (res_taken != res_pred);
  assign redirect   = res_taken ? res_addr : res_pc + 32'd4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb.wen    <= 1'b0;
      upd_valid <= 1'b0;
    end else begin
      wb.wen    <= accept;
      upd_valid <= accept && is_branch;   // Train on every resolved branch
    end
  end

  // Payload, qualified by the registered valids
  always_ff @(posedge CLK) begin
    if (accept) begin
      wb.index      <= res_index;
      wb.wdata      <= res_wdata;
      wb.rd         <= res_rd;
      wb.exc_cause  <= cause;
      wb.badaddr    <= res_addr;
      wb.mispredict <= mispredict;
      wb.redirect   <= redirect;
      upd_pc        <= res_pc;
      upd_taken     <= res_taken;
    end
  end

endmodule

//--- completion_buffer.sv
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module completion_buffer import ooo_types_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        alloc_valid,
  input  word_t       alloc_pc,
  output cb_idx_t     alloc_index,
  commit_wb_if.buffer wb,
  output logic        retire_valid,
  output logic        reg_wen,
  output reg_idx_t    reg_waddr,
  output word_t       reg_wdata,
  output logic        exc_valid,
  output exc_cause_t  exc_cause,
  output word_t       exc_epc,
  output word_t       exc_badaddr,
  output logic        redirect_valid,
  output word_t       redirect_pc,
  output logic        flush,
  output logic        credit_return
);

  localparam int DEPTH = `OOO_CB_DEPTH;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  cb_state_t        state_q;
  cb_idx_t          head_q;
  cb_idx_t          tail_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic [DEPTH-1:0] done_q;     // Result has arrived

  word_t      pc_mem       [DEPTH];
  word_t      wdata_mem    [DEPTH];
  reg_idx_t   rd_mem       [DEPTH];
  exc_cause_t cause_mem    [DEPTH];
  word_t      badaddr_mem  [DEPTH];
  logic       fault_mem    [DEPTH];
  logic       mispred_mem  [DEPTH];
  word_t      redirect_mem [DEPTH];

  logic running;
  logic alloc_fire;
  logic write_fire;
  logic head_fault;
  logic head_mispred;

  assign running    = (state_q == CB_RUN);
  assign alloc_fire = alloc_valid && running;
  assign write_fire = wb.wen && running;

  assign alloc_index = tail_q;

  // Head entry drives every retirement output
  assign head_fault   = fault_mem[head_q];
  assign head_mispred = mispred_mem[head_q];

  assign retire_valid   = running && (count_q != '0) && done_q[head_q];
  assign exc_valid      = retire_valid && head_fault;
  assign redirect_valid = retire_valid && !head_fault && head_mispred;
  assign credit_return  = retire_valid && !head_fault && !head_mispred;
  assign reg_wen        = credit_return && (rd_mem[head_q] != '0);

  assign reg_waddr   = rd_mem[head_q];
  assign reg_wdata   = wdata_mem[head_q];
  assign exc_cause   = cause_mem[head_q];
  assign exc_epc     = pc_mem[head_q];
  assign exc_badaddr = badaddr_mem[head_q];
  assign redirect_pc = redirect_mem[head_q];

  assign flush    = (state_q == CB_FLUSH);
  assign wb.flush = flush;

  always_comb begin
    count_d = count_q;
    if (alloc_fire && !retire_valid) begin
      count_d = count_q + 1'b1;
    end else if (!alloc_fire && retire_valid) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= CB_RUN;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else if (state_q == CB_FLUSH) begin
      state_q <= CB_RUN;                // Drop every entry, credits back to full
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (exc_valid || redirect_valid) begin
        state_q <= CB_FLUSH;
      end
      if (alloc_fire) begin
        tail_q         <= tail_q + 1'b1;
        done_q[tail_q] <= 1'b0;
      end
      if (write_fire) begin
        done_q[wb.index] <= 1'b1;
      end
      if (retire_valid) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_d;
    end
  end

  // Entry storage
  always_ff @(posedge CLK) begin
    if (alloc_fire) begin
      pc_mem[tail_q] <= alloc_pc;
    end
    if (write_fire) begin
      wdata_mem[wb.index]    <= wb.wdata;
      rd_mem[wb.index]       <= wb.rd;
      cause_mem[wb.index]    <= wb.exc_cause;
      badaddr_mem[wb.index]  <= wb.badaddr;
      fault_mem[wb.index]    <= (wb.exc_cause != EXC_NONE);
      mispred_mem[wb.index]  <= wb.mispredict;
      redirect_mem[wb.index] <= wb.redirect;
    end
  end

endmodule

//--- bimodal_predictor.sv
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module bimodal_predictor import ooo_types_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  upd_valid,
  input  word_t upd_pc,
  input  logic  upd_taken,
  input  word_t lookup_pc,
  output logic  lookup_taken
);

  localparam int ENTRIES = `OOO_BHT_ENTRIES;
  localparam int IDX_W   = $clog2(ENTRIES);

  bht_ctr_t         ctr_q [ENTRIES];
  logic [IDX_W-1:0] upd_idx;
  logic [IDX_W-1:0] lookup_idx;
  bht_ctr_t         upd_ctr;

  // Word-aligned PCs, so skip bits 1:0
  assign upd_idx    = upd_pc[IDX_W+1:2];
  assign lookup_idx = lookup_pc[IDX_W+1:2];

  assign lookup_taken = ctr_q[lookup_idx][1];   // Upper half predicts taken
  assign upd_ctr      = ctr_q[upd_idx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < ENTRIES; i++) begin
        ctr_q[i] <= 2'b01;                      // Weakly not-taken
      end
    end else if (upd_valid) begin
      if (upd_taken) begin
        if (upd_ctr != 2'b11) begin
          ctr_q[upd_idx] <= upd_ctr + 1'b1;
        end
      end else begin
        if (upd_ctr != 2'b00) begin
          ctr_q[upd_idx] <= upd_ctr - 1'b1;
        end
      end
    end
  end

endmodule

//--- ooo_backend_top.sv
`timescale 1ns/1ns

module ooo_backend_top import ooo_types_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         alloc_valid,
  input  word_t        alloc_pc,
  output cb_idx_t      alloc_index,
  input  logic         res_valid,
  input  cb_idx_t      res_index,
  input  result_kind_t res_kind,
  input  word_t        res_pc,
  input  word_t        res_wdata,
  input  word_t        res_addr,
  input  reg_idx_t     res_rd,
  input  logic         res_taken,
  input  logic         res_pred,
  input  word_t        lookup_pc,
  output logic         lookup_taken,
  output logic         retire_valid,
  output logic         reg_wen,
  output reg_idx_t     reg_waddr,
  output word_t        reg_wdata,
  output logic         exc_valid,
  output exc_cause_t   exc_cause,
  output word_t        exc_epc,
  output word_t        exc_badaddr,
  output logic         redirect_valid,
  output word_t        redirect_pc,
  output logic         flush,
  output logic         credit_return
);

  logic  upd_valid;
  word_t upd_pc;
  logic  upd_taken;

  commit_wb_if wb_if ();

  ooo_commit_stage commit_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .res_valid (res_valid),
    .res_index (res_index),
    .res_kind  (res_kind),
    .res_pc    (res_pc),
    .res_wdata (res_wdata),
    .res_addr  (res_addr),
    .res_rd    (res_rd),
    .res_taken (res_taken),
    .res_pred  (res_pred),
    .wb        (wb_if),
    .upd_valid (upd_valid),
    .upd_pc    (upd_pc),
    .upd_taken (upd_taken)
  );

  completion_buffer cb_inst (
    .CLK            (CLK),
    .nRST           (nRST),
    .alloc_valid    (alloc_valid),
    .alloc_pc       (alloc_pc),
    .alloc_index    (alloc_index),
    .wb             (wb_if),
    .retire_valid   (retire_valid),
    .reg_wen        (reg_wen),
    .reg_waddr      (reg_waddr),
    .reg_wdata      (reg_wdata),
    .exc_valid      (exc_valid),
    .exc_cause      (exc_cause),
    .exc_epc        (exc_epc),
    .exc_badaddr    (exc_badaddr),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .flush          (flush),
    .credit_return  (credit_return)
  );

  bimodal_predictor bht_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .upd_valid    (upd_valid),
    .upd_pc       (upd_pc),
    .upd_taken    (upd_taken),
    .lookup_pc    (lookup_pc),
    .lookup_taken (lookup_taken)
  );

endmodule

//--- ooo_backend_checker.sv
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module ooo_backend_checker (
  input logic CLK,
  input logic nRST,
  input logic alloc_valid,
  input logic retire_valid,
  input logic reg_wen,
  input logic exc_valid,
  input logic redirect_valid,
  input logic flush,
  input logic credit_return
);

  localparam int DEPTH = `OOO_CB_DEPTH;

  int credits_q;        // Credits held by the dispatcher
  int err_count = 0;    // Failed assertions so far

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      credits_q <= DEPTH;
    end else if (flush) begin
      credits_q <= DEPTH;                 // Whole buffer handed back
    end else begin
      credits_q <= credits_q - int'(alloc_valid) + int'(credit_return);
    end
  end

  a_credit: assert property (@(posedge CLK) disable iff (!nRST)
    alloc_valid |-> credits_q > 0)
    else begin
      $error("Allocation without a credit");
      err_count++;
    end

  a_one_outcome: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({reg_wen, exc_valid, redirect_valid}))
    else begin
      $error("More than one retirement outcome");
      err_count++;
    end

  a_flush_next: assert property (@(posedge CLK) disable iff (!nRST)
    (exc_valid || redirect_valid) |=> flush)
    else begin
      $error("No flush after exception or redirect");
      err_count++;
    end

  a_flush_cause: assert property (@(posedge CLK) disable iff (!nRST)
    flush |-> $past(exc_valid || redirect_valid))
    else begin
      $error("Flush without a cause");
      err_count++;
    end

  a_reset: assert property (@(posedge CLK) !nRST |->
    !(retire_valid || reg_wen || exc_valid || redirect_valid || flush || credit_return))
    else begin
      $error("Control output high during reset");
      err_count++;
    end

endmodule

//--- tb_ooo_backend.sv
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module tb_ooo_backend import ooo_types_pkg::*; ();

  localparam int         DEPTH       = `OOO_CB_DEPTH;
  localparam int         NUM_RESULTS = 33;     // Sum of all batch sizes
  localparam logic [1:0] RET_NORMAL  = 2'd0;
  localparam logic [1:0] RET_EXC     = 2'd1;
  localparam logic [1:0] RET_REDIR   = 2'd2;

  typedef struct packed {
    logic [1:0] how;
    reg_idx_t   rd;
    word_t      wdata;
    exc_cause_t cause;
    word_t      epc;
    word_t      badaddr;
    word_t      target;
  } exp_t;

  logic         CLK;
  logic         nRST;
  logic         alloc_valid;
  word_t        alloc_pc;
  cb_idx_t      alloc_index;
  logic         res_valid;
  cb_idx_t      res_index;
  result_kind_t res_kind;
  word_t        res_pc;
  word_t        res_wdata;
  word_t        res_addr;
  reg_idx_t     res_rd;
  logic         res_taken;
  logic         res_pred;
  word_t        lookup_pc;
  logic         lookup_taken;
  logic         retire_valid;
  logic         reg_wen;
  reg_idx_t     reg_waddr;
  word_t        reg_wdata;
  logic         exc_valid;
  exc_cause_t   exc_cause;
  word_t        exc_epc;
  word_t        exc_badaddr;
  logic         redirect_valid;
  word_t        redirect_pc;
  logic         flush;
  logic         credit_return;

  integer  seed;
  string   cur_test;
  int      credits;                      // Dispatcher credits in the model
  cb_idx_t exp_tail;
  exp_t    exp_q[$];                     // Pending retirements, oldest first
  exp_t    ret_e;
  int      bht_m [`OOO_BHT_ENTRIES];

  // Batch under construction in allocation order
  word_t        e_pc [DEPTH];
  result_kind_t e_kind [DEPTH];
  word_t        e_wdata [DEPTH];
  word_t        e_addr [DEPTH];
  reg_idx_t     e_rd [DEPTH];
  logic         e_taken [DEPTH];
  logic         e_pred [DEPTH];
  cb_idx_t      e_idx [DEPTH];

  ooo_backend_top ooo_backend_top_inst (.*);

  bind ooo_backend_top ooo_backend_checker chk_inst (.*);

  always #5 CLK = ~CLK;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    string msg;
    assert (exp === act) else begin
      msg = $sformatf("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
      stop_on_error(msg);
    end
  endtask

  task automatic set_entry(input int i, input word_t pc, input result_kind_t kind,
                           input word_t wdata, input word_t addr, input reg_idx_t rd,
                           input logic taken, input logic pred);
    e_pc[i]    = pc;
    e_kind[i]  = kind;
    e_wdata[i] = wdata;
    e_addr[i]  = addr;
    e_rd[i]    = rd;
    e_taken[i] = taken;
    e_pred[i]  = pred;
  endtask

  // Faults win over a misprediction
  function automatic exp_t expected_outcome(input int i);
    exp_t e;
    logic mis;
    mis       = (e_addr[i][1:0] != 2'b00);
    e         = '0;
    e.how     = RET_NORMAL;
    e.rd      = e_rd[i];
    e.wdata   = e_wdata[i];
    e.cause   = EXC_NONE;
    e.epc     = e_pc[i];
    e.badaddr = e_addr[i];
    if (mis && e_kind[i] == RK_LOAD) begin
      e.how   = RET_EXC;
      e.cause = EXC_MAL_LOAD;
    end else if (mis && e_kind[i] == RK_STORE) begin
      e.how   = RET_EXC;
      e.cause = EXC_MAL_STORE;
    end else if (mis && (e_kind[i] == RK_JUMP || (e_kind[i] == RK_BRANCH && e_taken[i]))) begin
      e.how   = RET_EXC;
      e.cause = EXC_MAL_INSN;
    end else if (e_kind[i] == RK_BRANCH && e_taken[i] != e_pred[i]) begin
      e.how    = RET_REDIR;
      e.target = e_taken[i] ? e_addr[i] : e_pc[i] + 32'd4;
    end
    return e;
  endfunction

  task automatic train_model(input word_t pc, input logic taken);
    int idx;
    idx = (pc >> 2) % `OOO_BHT_ENTRIES;
    if (taken)
      bht_m[idx] = (bht_m[idx] < 3) ? bht_m[idx] + 1 : 3;
    else
      bht_m[idx] = (bht_m[idx] > 0) ? bht_m[idx] - 1 : 0;
  endtask

  task automatic alloc_batch(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge CLK);
      #1;
      alloc_valid = 1'b1;
      alloc_pc    = e_pc[i];
      @(negedge CLK);
      check_eq("alloc_index", exp_tail, alloc_index);
      e_idx[i] = exp_tail;
      exp_q.push_back(expected_outcome(i));
      exp_tail++;
      credits--;
    end
    @(posedge CLK);
    #1;
    alloc_valid = 1'b0;
  endtask

  // Oldest entry goes last so nothing retires mid-batch
  task automatic send_results(input int n);
    int ord [DEPTH];
    int j;
    int tmp;
    int k;
    for (int i = 0; i < n; i++)
      ord[i] = (i + 1) % n;
    for (int i = n - 2; i > 0; i--) begin
      j      = $unsigned($random(seed)) % (i + 1);
      tmp    = ord[i];
      ord[i] = ord[j];
      ord[j] = tmp;
    end
    for (int i = 0; i < n; i++) begin
      k = ord[i];
      @(posedge CLK);
      #1;
      res_valid = 1'b1;
      res_index = e_idx[k];
      res_kind  = e_kind[k];
      res_pc    = e_pc[k];
      res_wdata = e_wdata[k];
      res_addr  = e_addr[k];
      res_rd    = e_rd[k];
      res_taken = e_taken[k];
      res_pred  = e_pred[k];
      if (e_kind[k] == RK_BRANCH)
        train_model(e_pc[k], e_taken[k]);
    end
    @(posedge CLK);
    #1;
    res_valid = 1'b0;
  endtask

  task automatic run_batch(input int n);
    alloc_batch(n);
    send_results(n);
    while (exp_q.size() != 0)
      @(negedge CLK);
    repeat (2) @(negedge CLK);          // Room for a trailing flush
    check_eq("credits", DEPTH, credits);
  endtask

  task automatic check_predictor();
    for (int k = 0; k < `OOO_BHT_ENTRIES; k++) begin
      @(posedge CLK);
      #1;
      lookup_pc = 32'h200 + 4 * k;
      @(negedge CLK);
      check_eq($sformatf("lookup_taken pc %h", lookup_pc), bht_m[k] >= 2, lookup_taken);
    end
  endtask

  // Retirement monitor
  always @(negedge CLK) begin
    if (nRST) begin
      if (ooo_backend_top_inst.chk_inst.err_count != 0)
        stop_on_error("A concurrent assertion in the checker failed");
      if (flush) begin
        credits  = DEPTH;
        exp_tail = '0;
      end
      if (retire_valid) begin
        if (exp_q.size() == 0)
          stop_on_error("An entry retired that the model had already discarded");
        ret_e = exp_q.pop_front();
        check_eq("credit_return", ret_e.how == RET_NORMAL, credit_return);
        check_eq("reg_wen", ret_e.how == RET_NORMAL && ret_e.rd != 0, reg_wen);
        check_eq("exc_valid", ret_e.how == RET_EXC, exc_valid);
        check_eq("redirect_valid", ret_e.how == RET_REDIR, redirect_valid);
        if (reg_wen) begin
          check_eq("reg_waddr", ret_e.rd, reg_waddr);
          check_eq("reg_wdata", ret_e.wdata, reg_wdata);
        end
        if (exc_valid) begin
          check_eq("exc_cause", ret_e.cause, exc_cause);
          check_eq("exc_epc", ret_e.epc, exc_epc);
          check_eq("exc_badaddr", ret_e.badaddr, exc_badaddr);
        end
        if (redirect_valid)
          check_eq("redirect_pc", ret_e.target, redirect_pc);
        if (ret_e.how == RET_NORMAL)
          credits++;
        else
          exp_q.delete();               // Younger entries die in the flush
      end
    end
  end

  initial begin
    #(60 * NUM_RESULTS * 10);
    stop_on_error("Watchdog timeout, the DUT stopped retiring results");
  end

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    alloc_valid = 1'b0;
    alloc_pc = '0;
    res_valid = 1'b0;
    res_index = '0;
    res_kind = RK_ALU;
    res_pc = '0;
    res_wdata = '0;
    res_addr = '0;
    res_rd = '0;
    res_taken = 1'b0;
    res_pred = 1'b0;
    lookup_pc = '0;
    seed = 79088;
    credits = DEPTH;
    exp_tail = '0;
    for (int k = 0; k < `OOO_BHT_ENTRIES; k++)
      bht_m[k] = 1;                     // Weakly not-taken
    cur_test = "reset";
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;

    cur_test = "in_order";
    for (int i = 0; i < 8; i++)
      set_entry(i, 32'h1000 + 4 * i, RK_ALU, $random(seed), 32'h0, reg_idx_t'(i), 1'b0, 1'b0);
    run_batch(8);

    cur_test = "misaligned_ldst";
    set_entry(0, 32'h2000, RK_LOAD, 32'h11, 32'h8000, 5'd3, 1'b0, 1'b0);
    set_entry(1, 32'h2004, RK_ALU, 32'h22, 32'h0, 5'd4, 1'b0, 1'b0);
    set_entry(2, 32'h2008, RK_LOAD, 32'h33, 32'h8001, 5'd5, 1'b0, 1'b0);
    set_entry(3, 32'h200C, RK_ALU, 32'h44, 32'h0, 5'd6, 1'b0, 1'b0);
    run_batch(4);
    set_entry(0, 32'h2010, RK_STORE, 32'h0, 32'h9004, 5'd0, 1'b0, 1'b0);
    set_entry(1, 32'h2014, RK_STORE, 32'h0, 32'h9006, 5'd0, 1'b0, 1'b0);
    run_batch(2);

    cur_test = "misaligned_target";
    set_entry(0, 32'h3000, RK_BRANCH, 32'h0, 32'h3102, 5'd0, 1'b0, 1'b0);
    set_entry(1, 32'h3004, RK_JUMP, 32'h3008, 32'h3201, 5'd1, 1'b0, 1'b0);
    run_batch(2);
    set_entry(0, 32'h3010, RK_BRANCH, 32'h0, 32'h3402, 5'd0, 1'b1, 1'b1);
    run_batch(1);

    cur_test = "mispredict";
    set_entry(0, 32'h4000, RK_ALU, 32'h55, 32'h0, 5'd7, 1'b0, 1'b0);
    set_entry(1, 32'h4004, RK_BRANCH, 32'h0, 32'h4100, 5'd0, 1'b1, 1'b0);
    set_entry(2, 32'h4008, RK_ALU, 32'h66, 32'h0, 5'd8, 1'b0, 1'b0);
    run_batch(3);
    set_entry(0, 32'h4100, RK_BRANCH, 32'h0, 32'h4300, 5'd0, 1'b0, 1'b1);
    run_batch(1);
    set_entry(0, 32'h4104, RK_ALU, 32'h77, 32'h0, 5'd9, 1'b0, 1'b0);
    set_entry(1, 32'h4108, RK_ALU, 32'h88, 32'h0, 5'd10, 1'b0, 1'b0);
    run_batch(2);

    cur_test = "predictor";
    for (int i = 0; i < 4; i++)
      set_entry(i, 32'h5008, RK_BRANCH, 32'h0, 32'h5100, 5'd0, 1'b1, 1'b1);
    for (int i = 4; i < 7; i++)
      set_entry(i, 32'h500C, RK_BRANCH, 32'h0, 32'h5200, 5'd0, 1'b0, 1'b0);
    set_entry(7, 32'h5010, RK_BRANCH, 32'h0, 32'h5300, 5'd0, 1'b1, 1'b1);
    run_batch(8);
    check_predictor();
    set_entry(0, 32'h5008, RK_BRANCH, 32'h0, 32'h5100, 5'd0, 1'b0, 1'b0);
    set_entry(1, 32'h500C, RK_BRANCH, 32'h0, 32'h5200, 5'd0, 1'b1, 1'b1);
    run_batch(2);
    check_predictor();                  // Saturated counters hold their side

    if (ooo_backend_top_inst.chk_inst.err_count != 0) begin
      stop_on_error("A concurrent assertion in the checker failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- filelist.f
+incdir+.
ooo_types_pkg.sv
commit_wb_if.sv
ooo_commit_stage.sv
completion_buffer.sv
bimodal_predictor.sv
ooo_backend_top.sv
ooo_backend_checker.sv
tb_ooo_backend.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into a log and scan the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ooo_backend -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+10 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

grep -q "Some tests failed" "$LOG"
grep_status=$?
if [ $grep_status -eq 0 ]; then
  echo "Simulation FAILED"
  exit 1
elif [ $grep_status -ne 1 ]; then
  echo "Could not search $LOG"
  exit 1
fi
echo "Simulation PASSED"
exit 0
